/* src/genbus_pkg.sv */
// Main bus shared types
package genbus_pkg;

	// ------------------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------------------

	// 68000 word address, byte select carried by uds and lds
	typedef logic [23:1] bus_addr_t;
	typedef logic [15:0] bus_data_t;
	typedef logic [15:0] z80_addr_t;
	typedef logic [7:0]  z80_data_t;

	// Upper address bits of the Z80 banked window
	typedef logic [23:15] bank_t;

	// ------------------------------------------------------------------------
	// Requests and external bus
	// ------------------------------------------------------------------------

	// Byte enables are active high
	typedef struct packed {
		logic      valid;
		bus_addr_t addr;
		bus_data_t wdata;
		logic      rnw;
		logic      uds;
		logic      lds;
	} mreq_t;

	// Asel marks the lower half of the 68000 space
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t wdata;
		logic      rnw;
		logic      uds;
		logic      lds;
		logic      asel;
	} ext_bus_t;

	typedef struct packed {
		logic      valid;
		z80_addr_t addr;
		z80_data_t wdata;
		logic      wr;
	} z80_req_t;

	// ------------------------------------------------------------------------
	// Decode and arbiter states
	// ------------------------------------------------------------------------

	typedef enum logic [1:0] {REG_ROM, REG_RAM, REG_CTRL, REG_NONE} region_t;

	typedef enum logic [2:0] {
		ST_IDLE, ST_SELECT, ST_ROM_WAIT, ST_RAM_WAIT,
		ST_RAM_READ, ST_RAM_WRITE, ST_NONE, ST_FINISH
	} mbus_state_t;

	// NOP opcode seen on an undriven bus
	localparam bus_data_t OPEN_BUS_RESET = 16'h4E71;

endpackage

/* src/region_decode.sv */
// Bus region decoder
`timescale 1ns/10ps

module region_decode (
	input  genbus_pkg::bus_addr_t addr,
	input  logic                  cart_n,
	output genbus_pkg::region_t   region,
	output logic                  ce0_n,
	output logic                  rom_n,
	output logic                  ras2_n
);

	logic is_ctrl;

	// Only the words at A11100 and A11200
	assign is_ctrl = (addr[23:12] == 12'hA11) &&
		((addr[11:8] == 4'h1) || (addr[11:8] == 4'h2)) &&
		(addr[7:1] == 7'd0);

	always_comb begin
		if (!addr[23]) begin
			// 000000-7FFFFF
			region = genbus_pkg::REG_ROM;
		end else if (&addr[23:21]) begin
			// E00000-FFFFFF
			region = genbus_pkg::REG_RAM;
		end else if (is_ctrl) begin
			region = genbus_pkg::REG_CTRL;
		end else begin
			region = genbus_pkg::REG_NONE;
		end
	end

	// ------------------------------------------------------------------------
	// Cartridge chip selects
	// ------------------------------------------------------------------------

	// Lower or upper 4MB depending on cart_n
	assign ce0_n = ~(addr[23:22] == {1'b0, cart_n});

	// 2MB windows that swap with cart_n
	assign rom_n  = ~(addr[23:21] == {1'b0, ~cart_n, 1'b0});
	assign ras2_n = ~(addr[23:21] == {1'b0, ~cart_n, 1'b1});

endmodule

/* src/z80_bank_window.sv */
// Z80 banked window
`timescale 1ns/10ps

module z80_bank_window #(
	parameter logic [7:0] BANK_PAGE = 8'h60
) (
	input  logic                  MCLK,
	input  logic                  reset,
	input  genbus_pkg::z80_req_t  z80_req,
	input  logic                  mbus_dtack,
	input  genbus_pkg::bus_data_t mbus_rdata,
	output genbus_pkg::mreq_t     mbus_req,
	output logic                  z80_done,
	output genbus_pkg::z80_data_t z80_rdata
);

	genbus_pkg::bank_t bank;
	logic              vdp_page;
	logic              to_mbus;
	logic              bank_wr;
	logic              local_done;

	// 7Fxx still goes out to the main bus at C000xx
	assign vdp_page = (z80_req.addr[15:8] == 8'h7F);
	assign to_mbus  = z80_req.addr[15] | vdp_page;

	// One shift per access, before the local acknowledge
	assign bank_wr = z80_req.valid & z80_req.wr & ~local_done &
		(z80_req.addr[15:8] == BANK_PAGE);

	// ------------------------------------------------------------------------
	// Translation into the 68000 space
	// ------------------------------------------------------------------------
	always_comb begin
		mbus_req.valid = z80_req.valid & to_mbus;
		if (z80_req.addr[15]) begin
			mbus_req.addr = {bank, z80_req.addr[14:1]};
		end else begin
			mbus_req.addr = {16'hC000, z80_req.addr[7:1]};
		end
		mbus_req.wdata = {z80_req.wdata, z80_req.wdata};
		mbus_req.rnw   = ~z80_req.wr;
		// Even byte sits on the upper lane
		mbus_req.uds = ~z80_req.addr[0];
		mbus_req.lds = z80_req.addr[0];
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank       <= '0;
			local_done <= 1'b0;
		end else begin
			if (!z80_req.valid) begin
				local_done <= 1'b0;
			end else if (!to_mbus) begin
				local_done <= 1'b1;
			end
			if (bank_wr) begin
				bank <= {z80_req.wdata[0], bank[23:16]};
			end
		end
	end

	assign z80_done = local_done | mbus_dtack;

	// Nothing local is readable here
	assign z80_rdata = local_done ? 8'hFF :
		(z80_req.addr[0] ? mbus_rdata[7:0] : mbus_rdata[15:8]);

endmodule

/* src/ctrl_regs.sv */
// Z80 control register
`timescale 1ns/10ps

module ctrl_regs (
	input  logic                  MCLK,
	input  logic                  reset,
	input  logic                  sel,
	input  genbus_pkg::ext_bus_t  bus,
	input  logic                  z80_busack,
	output logic                  z80_busreq,
	output logic                  z80_reset_n,
	output genbus_pkg::bus_data_t rdata
);

	logic wr_en;
	logic flag;

	// Upper byte writes only
	assign wr_en = sel & ~bus.rnw & bus.uds;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busreq  <= 1'b0;
			z80_reset_n <= 1'b0;
		end else if (wr_en) begin
			if (bus.addr[8]) begin
				z80_busreq <= bus.wdata[8];
			end
			if (bus.addr[9]) begin
				z80_reset_n <= bus.wdata[8];
			end
		end
	end

	// A11100 reports busack, A11200 reports the reset line
	always_comb begin
		flag = 1'b0;
		if (bus.addr[8]) begin
			flag = z80_busack | ~z80_reset_n;
		end else if (bus.addr[9]) begin
			flag = z80_reset_n;
		end
	end

	assign rdata = {7'd0, flag, 8'd0};

endmodule

/* src/bus_arbiter.sv */
// Main bus arbiter
`timescale 1ns/10ps

module bus_arbiter (
	input  logic                  MCLK,
	input  logic                  reset,
	input  genbus_pkg::mreq_t     cpu_req,
	input  genbus_pkg::mreq_t     z80_req,
	input  genbus_pkg::mreq_t     dma_req,
	input  genbus_pkg::region_t   region,
	input  logic                  rom_dtack,
	input  logic                  ram_rdy,
	input  genbus_pkg::bus_data_t rom_rdata,
	input  genbus_pkg::bus_data_t ctrl_rdata,
	output genbus_pkg::ext_bus_t  ext_bus,
	output logic                  cpu_dtack,
	output logic                  z80_dtack,
	output logic                  dma_dtack,
	output logic                  ram_ce_n,
	output logic                  ctrl_sel,
	output genbus_pkg::bus_data_t rdata
);

	typedef enum logic [1:0] {SRC_CPU, SRC_Z80, SRC_DMA} src_t;

	localparam genbus_pkg::ext_bus_t EXT_IDLE = '{addr: '0, wdata: '0, rnw: 1'b1,
		uds: 1'b0, lds: 1'b0, asel: 1'b0};

	genbus_pkg::mbus_state_t state;
	src_t                    src;
	src_t                    win_src;
	genbus_pkg::mreq_t       win;
	logic                    cur_valid;
	logic [2:0]              src_hot;
	logic [2:0]              dtack_q;
	logic                    rom_sel;
	logic                    ram_sel;
	genbus_pkg::bus_data_t   open_bus;

	// CPU first, then Z80, then DMA
	always_comb begin
		win_src = SRC_DMA;
		win     = dma_req;
		if (cpu_req.valid) begin
			win_src = SRC_CPU;
			win     = cpu_req;
		end else if (z80_req.valid) begin
			win_src = SRC_Z80;
			win     = z80_req;
		end
	end

	always_comb begin
		case (src)
			SRC_CPU: cur_valid = cpu_req.valid;
			SRC_Z80: cur_valid = z80_req.valid;
			default: cur_valid = dma_req.valid;
		endcase
	end

	assign src_hot = {src == SRC_DMA, src == SRC_Z80, src == SRC_CPU};

	// ------------------------------------------------------------------------
	// Bus state machine
	// ------------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state    <= genbus_pkg::ST_IDLE;
			src      <= SRC_CPU;
			dtack_q  <= '0;
			rom_sel  <= 1'b0;
			ram_sel  <= 1'b0;
			ctrl_sel <= 1'b0;
			ext_bus  <= EXT_IDLE;
			open_bus <= genbus_pkg::OPEN_BUS_RESET;
		end else begin
			case (state)
				genbus_pkg::ST_IDLE: begin
					if (win.valid) begin
						src     <= win_src;
						ext_bus <= '{addr: win.addr, wdata: win.wdata, rnw: win.rnw,
							uds: win.uds, lds: win.lds, asel: ~win.addr[23]};
						state   <= genbus_pkg::ST_SELECT;
					end
				end
				genbus_pkg::ST_SELECT: begin
					case (region)
						genbus_pkg::REG_ROM: begin
							rom_sel <= 1'b1;
							state   <= genbus_pkg::ST_ROM_WAIT;
						end
						genbus_pkg::REG_RAM: begin
							ram_sel <= 1'b1;
							state   <= genbus_pkg::ST_RAM_WAIT;
						end
						genbus_pkg::REG_CTRL: begin
							ctrl_sel <= 1'b1;
							dtack_q  <= src_hot;
							state    <= genbus_pkg::ST_FINISH;
						end
						default: begin
							state <= genbus_pkg::ST_NONE;
						end
					endcase
				end
				genbus_pkg::ST_ROM_WAIT: begin
					if (rom_dtack) begin
						dtack_q <= src_hot;
						state   <= genbus_pkg::ST_FINISH;
					end
				end
				genbus_pkg::ST_RAM_WAIT: begin
					// RAM accepts the cycle by pulling ready low
					if (!ram_rdy) begin
						state <= ext_bus.rnw ? genbus_pkg::ST_RAM_READ : genbus_pkg::ST_RAM_WRITE;
					end
				end
				genbus_pkg::ST_RAM_READ: begin
					if (ram_rdy) begin
						dtack_q <= src_hot;
						state   <= genbus_pkg::ST_FINISH;
					end
				end
				genbus_pkg::ST_RAM_WRITE, genbus_pkg::ST_NONE: begin
					dtack_q <= src_hot;
					state   <= genbus_pkg::ST_FINISH;
				end
				genbus_pkg::ST_FINISH: begin
					// Hold until the owner releases its request
					if (!cur_valid) begin
						dtack_q  <= '0;
						rom_sel  <= 1'b0;
						ram_sel  <= 1'b0;
						ctrl_sel <= 1'b0;
						ext_bus  <= EXT_IDLE;
						state    <= genbus_pkg::ST_IDLE;
						if (src == SRC_CPU) begin
							open_bus <= rdata;
						end
					end
				end
				default: begin
					state <= genbus_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// ROM and RAM share the external data bus
	always_comb begin
		if (rom_sel || ram_sel) begin
			rdata = rom_rdata;
		end else if (ctrl_sel) begin
			rdata = ctrl_rdata;
		end else begin
			rdata = open_bus;
		end
	end

	assign cpu_dtack = dtack_q[0];
	assign z80_dtack = dtack_q[1];
	assign dma_dtack = dtack_q[2];
	assign ram_ce_n  = ~ram_sel;

endmodule

/* src/genbus_top.sv */
// Main bus top level
`timescale 1ns/10ps

module genbus_top #(
	parameter logic [7:0] BANK_PAGE = 8'h60
) (
	input  logic                  MCLK,
	input  logic                  reset,
	input  logic                  cart_n,
	input  genbus_pkg::mreq_t     cpu_req,
	input  genbus_pkg::mreq_t     dma_req,
	input  genbus_pkg::z80_req_t  z80_req,
	input  logic                  rom_dtack,
	input  logic                  ram_rdy,
	input  genbus_pkg::bus_data_t rom_rdata,
	input  logic                  z80_busack,
	output genbus_pkg::ext_bus_t  ext_bus,
	output logic                  ce0_n,
	output logic                  rom_n,
	output logic                  ras2_n,
	output logic                  ram_ce_n,
	output logic                  cpu_dtack,
	output logic                  dma_dtack,
	output genbus_pkg::bus_data_t cpu_rdata,
	output logic                  z80_done,
	output genbus_pkg::z80_data_t z80_rdata,
	output logic                  z80_busreq,
	output logic                  z80_reset_n
);

	genbus_pkg::region_t   region;
	genbus_pkg::mreq_t     z80_mreq;
	genbus_pkg::bus_data_t ctrl_rdata;
	logic                  z80_dtack;
	logic                  ctrl_sel;

	region_decode decode_i (
		.addr   (ext_bus.addr),
		.cart_n (cart_n),
		.region (region),
		.ce0_n  (ce0_n),
		.rom_n  (rom_n),
		.ras2_n (ras2_n)
	);

	z80_bank_window #(.BANK_PAGE(BANK_PAGE)) window_i (
		.MCLK       (MCLK),
		.reset      (reset),
		.z80_req    (z80_req),
		.mbus_dtack (z80_dtack),
		.mbus_rdata (cpu_rdata),
		.mbus_req   (z80_mreq),
		.z80_done   (z80_done),
		.z80_rdata  (z80_rdata)
	);

	ctrl_regs ctrl_i (
		.MCLK        (MCLK),
		.reset       (reset),
		.sel         (ctrl_sel),
		.bus         (ext_bus),
		.z80_busack  (z80_busack),
		.z80_busreq  (z80_busreq),
		.z80_reset_n (z80_reset_n),
		.rdata       (ctrl_rdata)
	);

	// Shared read data goes to every requester
	bus_arbiter arbiter_i (
		.MCLK       (MCLK),
		.reset      (reset),
		.cpu_req    (cpu_req),
		.z80_req    (z80_mreq),
		.dma_req    (dma_req),
		.region     (region),
		.rom_dtack  (rom_dtack),
		.ram_rdy    (ram_rdy),
		.rom_rdata  (rom_rdata),
		.ctrl_rdata (ctrl_rdata),
		.ext_bus    (ext_bus),
		.cpu_dtack  (cpu_dtack),
		.z80_dtack  (z80_dtack),
		.dma_dtack  (dma_dtack),
		.ram_ce_n   (ram_ce_n),
		.ctrl_sel   (ctrl_sel),
		.rdata      (cpu_rdata)
	);

endmodule

/* testbench/genbus_assert.sv */
// Main bus protocol assertions
`timescale 1ns/10ps

module genbus_assert (
	input logic                 MCLK,
	input logic                 reset,
	input genbus_pkg::mreq_t    cpu_req,
	input genbus_pkg::mreq_t    dma_req,
	input genbus_pkg::mreq_t    z80_mreq,
	input logic                 cpu_dtack,
	input logic                 z80_dtack,
	input logic                 dma_dtack,
	input logic                 ram_ce_n,
	input genbus_pkg::ext_bus_t ext_bus
);

	one_dtack: assert property (@(posedge MCLK) disable iff (reset)
		$onehot0({cpu_dtack, z80_dtack, dma_dtack}))
		else $error("More than one dtack is high");

	// RAM select only inside a captured cycle
	ram_in_cycle: assert property (@(posedge MCLK) disable iff (reset)
		!ram_ce_n |-> (ext_bus.uds || ext_bus.lds))
		else $error("ram_ce_n low while ext_bus is idle");

	// Each dtack is set on an edge that saw its request
	cpu_dtack_req: assert property (@(posedge MCLK) disable iff (reset)
		$rose(cpu_dtack) |-> $past(cpu_req.valid))
		else $error("cpu_dtack rose without a CPU request");
	z80_dtack_req: assert property (@(posedge MCLK) disable iff (reset)
		$rose(z80_dtack) |-> $past(z80_mreq.valid))
		else $error("z80_dtack rose without a Z80 request");
	dma_dtack_req: assert property (@(posedge MCLK) disable iff (reset)
		$rose(dma_dtack) |-> $past(dma_req.valid))
		else $error("dma_dtack rose without a DMA request");

endmodule

/* testbench/genbus_tb.sv */
// Main bus testbench
`timescale 1ns/10ps

module genbus_tb;

	// About 40 bus cycles of at most a dozen clocks each, with wide margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic                  MCLK;
	logic                  reset;
	logic                  cart_n;
	genbus_pkg::mreq_t     cpu_req;
	genbus_pkg::mreq_t     dma_req;
	genbus_pkg::z80_req_t  z80_req;
	logic                  rom_dtack;
	logic                  ram_rdy;
	genbus_pkg::bus_data_t rom_rdata;
	logic                  z80_busack;
	genbus_pkg::ext_bus_t  ext_bus;
	logic                  ce0_n;
	logic                  rom_n;
	logic                  ras2_n;
	logic                  ram_ce_n;
	logic                  cpu_dtack;
	logic                  dma_dtack;
	genbus_pkg::bus_data_t cpu_rdata;
	logic                  z80_done;
	genbus_pkg::z80_data_t z80_rdata;
	logic                  z80_busreq;
	logic                  z80_reset_n;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	integer      seed = 32'h8a6b;
	logic [31:0] rnd;
	logic        rom_busy;
	logic [1:0]  rom_wait;
	int          ram_phase;
	logic [2:0]  cs_at_dtack;
	genbus_pkg::bus_data_t ram_mem [genbus_pkg::bus_addr_t];

	genbus_top #(.BANK_PAGE(8'h60)) dut_i (.*);

	bind genbus_top genbus_assert assert_i (
		.MCLK(MCLK), .reset(reset), .cpu_req(cpu_req), .dma_req(dma_req),
		.z80_mreq(z80_mreq), .cpu_dtack(cpu_dtack), .z80_dtack(z80_dtack),
		.dma_dtack(dma_dtack), .ram_ce_n(ram_ce_n), .ext_bus(ext_bus)
	);

	initial begin
		MCLK = 1'b0;
		forever #2 MCLK = ~MCLK;
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge MCLK);
			cycles++;
		end
		$display("Timeout: no bus response within %0d cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ------------------------------------------------------------------------
	// Device models, ROM with random latency and RAM behind ram_rdy
	// ------------------------------------------------------------------------
	function automatic genbus_pkg::bus_data_t rom_word(input logic [23:0] baddr);
		return baddr[16:1] ^ 16'h5A5A;
	endfunction

	function automatic genbus_pkg::bus_data_t fill_word(input genbus_pkg::bus_addr_t a);
		return a[16:1] ^ {9'd0, a[23:17]} ^ 16'hC3C3;
	endfunction

	// Active-low {ce0_n, rom_n, ras2_n} for a byte address
	function automatic logic [2:0] expected_selects(input logic [23:0] baddr,
			input logic no_cart);
		logic ce0;
		logic rom;
		logic ras2;
		if (!no_cart) begin
			ce0  = baddr < 24'h400000;
			rom  = (baddr >= 24'h400000) && (baddr < 24'h600000);
			ras2 = (baddr >= 24'h600000) && (baddr < 24'h800000);
		end else begin
			ce0  = (baddr >= 24'h400000) && (baddr < 24'h800000);
			rom  = baddr < 24'h200000;
			ras2 = (baddr >= 24'h200000) && (baddr < 24'h400000);
		end
		return {~ce0, ~rom, ~ras2};
	endfunction

	always @(posedge MCLK) begin
		#1;
		if (!(ext_bus.uds || ext_bus.lds)) begin
			rom_dtack = 1'b0;
			rom_busy  = 1'b0;
		end else if (ext_bus.asel && !rom_busy) begin
			rom_busy = 1'b1;
			rnd      = $random(seed);
			rom_wait = rnd[1:0];
		end else if (rom_busy && !rom_dtack) begin
			if (rom_wait == 2'd0) begin
				rom_dtack = 1'b1;
				rom_rdata = ext_bus.addr[16:1] ^ 16'h5A5A;
			end else begin
				rom_wait = rom_wait - 2'd1;
			end
		end
		if (ram_ce_n) begin
			ram_rdy   = 1'b1;
			ram_phase = 0;
		end else if (ram_phase == 0) begin
			// Accept the cycle, writes land here
			ram_rdy   = 1'b0;
			ram_phase = 1;
			if (!ram_mem.exists(ext_bus.addr)) begin
				ram_mem[ext_bus.addr] = fill_word(ext_bus.addr);
			end
			if (!ext_bus.rnw && ext_bus.uds) begin
				ram_mem[ext_bus.addr][15:8] = ext_bus.wdata[15:8];
			end
			if (!ext_bus.rnw && ext_bus.lds) begin
				ram_mem[ext_bus.addr][7:0] = ext_bus.wdata[7:0];
			end
		end else if (ram_phase == 1) begin
			ram_rdy   = 1'b1;
			ram_phase = 2;
			rom_rdata = ram_mem[ext_bus.addr];
		end
	end

	// ------------------------------------------------------------------------
	// Access and check tasks
	// ------------------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic cpu_cycle(input logic [23:0] baddr, input genbus_pkg::bus_data_t wdata,
			input logic rnw, input logic uds, input logic lds,
			output genbus_pkg::bus_data_t data, output genbus_pkg::ext_bus_t bus,
			output int edges);
		@(posedge MCLK);
		#1;
		edges   = 0;
		cpu_req = '{valid: 1'b1, addr: baddr[23:1], wdata: wdata, rnw: rnw, uds: uds, lds: lds};
		do begin
			@(posedge MCLK);
			#1;
			edges++;
		end while (!cpu_dtack);
		data = cpu_rdata;
		bus  = ext_bus;
		cs_at_dtack = {ce0_n, rom_n, ras2_n};
		cpu_req.valid = 1'b0;
		while (cpu_dtack) begin
			@(posedge MCLK);
			#1;
		end
	endtask

	task automatic z80_cycle(input genbus_pkg::z80_addr_t addr,
			input genbus_pkg::z80_data_t wdata, input logic wr,
			output genbus_pkg::z80_data_t data, output genbus_pkg::ext_bus_t bus);
		@(posedge MCLK);
		#1;
		z80_req = '{valid: 1'b1, addr: addr, wdata: wdata, wr: wr};
		do begin
			@(posedge MCLK);
			#1;
		end while (!z80_done);
		data = z80_rdata;
		bus  = ext_bus;
		z80_req.valid = 1'b0;
		while (z80_done) begin
			@(posedge MCLK);
			#1;
		end
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset_state();
		genbus_pkg::bus_data_t d;
		genbus_pkg::ext_bus_t  b;
		int                    n;
		check_value("reset_dtacks", 32'(0), 32'({cpu_dtack, dma_dtack, z80_done}));
		check_value("reset_ram_ce_n", 32'(1), 32'(ram_ce_n));
		check_value("reset_ext_bus", 32'(3'b100), 32'({ext_bus.rnw, ext_bus.uds, ext_bus.lds}));
		check_value("reset_z80_ctrl", 32'(0), 32'({z80_busreq, z80_reset_n}));
		cpu_cycle(24'hC00000, 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
		check_value("reset_open_bus", 32'(16'h4E71), 32'(d));
		check_value("unmapped_latency", 32'(3), 32'(n));
	endtask

	task automatic test_rom_open_bus();
		genbus_pkg::bus_data_t d;
		genbus_pkg::ext_bus_t  b;
		int                    n;
		cpu_cycle(24'h012344, 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
		check_value("rom_read", 32'(rom_word(24'h012344)), 32'(d));
		cpu_cycle(24'hA10000, 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
		check_value("open_bus_read", 32'(rom_word(24'h012344)), 32'(d));
	endtask

	task automatic test_ram_bytes();
		genbus_pkg::bus_data_t d;
		genbus_pkg::ext_bus_t  b;
		int                    n;
		cpu_cycle(24'hFF0010, 16'h1234, 1'b0, 1'b1, 1'b1, d, b, n);
		check_value("ram_word_bus", 32'({24'hFF0010 >> 1, 2'b11}), 32'({b.addr, b.uds, b.lds}));
		cpu_cycle(24'hFF0010, 16'hABEE, 1'b0, 1'b1, 1'b0, d, b, n);
		check_value("ram_upper_bus", 32'({24'hFF0010 >> 1, 2'b10}), 32'({b.addr, b.uds, b.lds}));
		cpu_cycle(24'hFF0010, 16'h77CD, 1'b0, 1'b0, 1'b1, d, b, n);
		check_value("ram_lower_bus", 32'({24'hFF0010 >> 1, 2'b01}), 32'({b.addr, b.uds, b.lds}));
		cpu_cycle(24'hFF0010, 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
		check_value("ram_merged_read", 32'(16'hABCD), 32'(d));
		cpu_cycle(24'hE00400, 16'h5AA5, 1'b0, 1'b1, 1'b1, d, b, n);
		cpu_cycle(24'hE00400, 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
		check_value("ram_second_read", 32'(16'h5AA5), 32'(d));
	endtask

	task automatic test_ctrl_regs();
		genbus_pkg::bus_data_t d;
		genbus_pkg::ext_bus_t  b;
		int                    n;
		// Z80 held in reset, so A11100 reads one
		cpu_cycle(24'hA11100, 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
		check_value("ctrl_busack_in_reset", 32'(16'h0100), 32'(d));
		cpu_cycle(24'hA11100, 16'h0100, 1'b0, 1'b1, 1'b0, d, b, n);
		check_value("ctrl_busreq", 32'(1), 32'(z80_busreq));
		cpu_cycle(24'hA11200, 16'h0100, 1'b0, 1'b1, 1'b0, d, b, n);
		check_value("ctrl_reset_n", 32'(1), 32'(z80_reset_n));
		z80_busack = 1'b0;
		cpu_cycle(24'hA11100, 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
		check_value("ctrl_busack_low", 32'(16'h0000), 32'(d));
		z80_busack = 1'b1;
		cpu_cycle(24'hA11100, 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
		check_value("ctrl_busack_high", 32'(16'h0100), 32'(d));
		cpu_cycle(24'hA11200, 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
		check_value("ctrl_reset_read", 32'(16'h0100), 32'(d));
	endtask

	task automatic test_z80_window();
		logic [8:0]            bank_val;
		logic [23:0]           target;
		genbus_pkg::z80_data_t zd;
		genbus_pkg::ext_bus_t  b;
		bank_val = 9'h023;
		target   = {bank_val, 15'h0ABC};
		// First bit written ends up in bank bit 15
		for (int i = 0; i < 9; i++) begin
			z80_cycle(16'h6000, {7'd0, bank_val[i]}, 1'b1, zd, b);
		end
		z80_cycle(16'h8ABC, 8'h00, 1'b0, zd, b);
		check_value("z80_bank_addr", 32'(target[23:1]), 32'(b.addr));
		check_value("z80_even_byte", 32'(rom_word(target) >> 8), 32'(zd));
		z80_cycle(16'h8ABD, 8'h00, 1'b0, zd, b);
		check_value("z80_odd_byte", 32'(rom_word(target) & 16'h00FF), 32'(zd));
		z80_cycle(16'h2010, 8'h00, 1'b0, zd, b);
		check_value("z80_local_read", 32'(8'hFF), 32'(zd));
	endtask

	task automatic test_priority();
		@(posedge MCLK);
		#1;
		cpu_req = '{valid: 1'b1, addr: 23'h000080, wdata: '0, rnw: 1'b1, uds: 1'b1, lds: 1'b1};
		dma_req = '{valid: 1'b1, addr: 23'h7F8008, wdata: '0, rnw: 1'b1, uds: 1'b1, lds: 1'b1};
		@(posedge MCLK);
		#1;
		check_value("prio_cpu_first", 32'(23'h000080), 32'(ext_bus.addr));
		while (!cpu_dtack) begin
			@(posedge MCLK);
			#1;
		end
		check_value("prio_cpu_data", 32'(rom_word(24'h000100)), 32'(cpu_rdata));
		cpu_req.valid = 1'b0;
		while (!dma_dtack) begin
			@(posedge MCLK);
			#1;
		end
		check_value("prio_dma_addr", 32'(23'h7F8008), 32'(ext_bus.addr));
		check_value("prio_dma_data", 32'(16'hABCD), 32'(cpu_rdata));
		dma_req.valid = 1'b0;
		while (dma_dtack) begin
			@(posedge MCLK);
			#1;
		end
	endtask

	// Cartridge selects with and without a cartridge
	task automatic test_chip_selects();
		genbus_pkg::bus_data_t d;
		genbus_pkg::ext_bus_t  b;
		int                    n;
		logic [23:0]           addrs [5];
		addrs = '{24'h012344, 24'h2ABCD0, 24'h400100, 24'h6F0000, 24'hA10000};
		for (int c = 0; c < 2; c++) begin
			cart_n = c[0];
			for (int i = 0; i < 5; i++) begin
				cpu_cycle(addrs[i], 16'h0000, 1'b1, 1'b1, 1'b1, d, b, n);
				check_value($sformatf("chip_selects_%0d_%h", c, addrs[i]),
					32'(expected_selects(addrs[i], cart_n)), 32'(cs_at_dtack));
			end
		end
		cart_n = 1'b0;
	endtask

	initial begin
		reset      = 1'b1;
		cart_n     = 1'b0;
		cpu_req    = '0;
		dma_req    = '0;
		z80_req    = '0;
		rom_dtack  = 1'b0;
		ram_rdy    = 1'b1;
		rom_rdata  = '0;
		z80_busack = 1'b0;
		rom_busy   = 1'b0;
		rom_wait   = 2'd0;
		ram_phase  = 0;
		repeat (3) @(posedge MCLK);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_rom_open_bus();
		test_ram_bytes();
		test_ctrl_regs();
		test_z80_window();
		test_priority();
		test_chip_selects();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* genbus_top.f */
src/genbus_pkg.sv
src/region_decode.sv
src/z80_bank_window.sv
src/ctrl_regs.sv
src/bus_arbiter.sv
src/genbus_top.sv
testbench/genbus_assert.sv
testbench/genbus_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the main bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module genbus_tb \
	-f genbus_top.f -Mdir obj_dir -o genbus_sim
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out=$(./obj_dir/genbus_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
